// ==== rtl/spi_bridge_defines.svh ====
`ifndef SPI_BRIDGE_DEFINES_SVH
`define SPI_BRIDGE_DEFINES_SVH

// byte address into the on-board memory, 128 KB.
`define SPI_ADDR_WIDTH 17

// flops between the pins and the system clock domain.
// sclk and mosi go through the same depth so they stay aligned.
`define SPI_SYNC_STAGES 2

// default wait states before the memory answers a request.
`define SRAM_WAIT_CYCLES 2

`endif

// ==== rtl/spi_bridge_pkg.sv ====
`include "spi_bridge_defines.svh"

package spi_bridge_pkg;

    // one byte on the wire, command or data.
    typedef logic [7:0] spi_byte_t;

    // memory byte address, A16 is the bank bit from the command.
    typedef logic [`SPI_ADDR_WIDTH-1:0] bus_addr_t;

    // bit 2 marks the transfer state and bit 3 the finished frame,
    // so valid and done fall out of a single bit each.
    typedef enum logic [3:0] {
        READ_CMD         = 4'b0000,
        READ_DATA_ARG    = 4'b0001,
        READ_ADDR_HI_ARG = 4'b0010,
        READ_ADDR_LO_ARG = 4'b0011,
        XFER             = 4'b0100,
        DONE             = 4'b1000
    } bridge_state_e;

endpackage

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/100ps

interface mem_bus_if;
    import spi_bridge_pkg::*;

    bus_addr_t addr;      // byte address of the transfer.
    spi_byte_t wdata;     // write data, stable while valid.
    logic      rw_n;      // 1 = read, 0 = write.
    logic      valid;     // level, held until ready.
    spi_byte_t rdata;     // read data, good in the ready cycle.
    logic      ready;     // one cycle pulse from the memory.

    modport bridge (
        output addr,
        output wdata,
        output rw_n,
        output valid,
        input  rdata,
        input  ready
    );

    modport memory (
        input  addr,
        input  wdata,
        input  rw_n,
        input  valid,
        output rdata,
        output ready
    );

endinterface

// ==== rtl/spi_byte.sv ====
`timescale 1ns/100ps
`include "spi_bridge_defines.svh"

module spi_byte (
    input  logic                    clk_sys_i,
    input  logic                    spi_sclk_i,
    input  logic                    spi_cs_ni,
    input  logic                    spi_rx_i,
    output logic                    spi_tx_o,
    input  spi_bridge_pkg::spi_byte_t tx_byte_i,
    output spi_bridge_pkg::spi_byte_t rx_byte_o,
    output logic                    rx_valid_o
);
    import spi_bridge_pkg::*;

    // one extra sclk flop holds the previous sample for edge detection.
    logic [`SPI_SYNC_STAGES:0]   sclk_sync;
    logic [`SPI_SYNC_STAGES-1:0] mosi_sync;

    logic      sclk_s;
    logic      sclk_prev;
    logic      mosi_s;
    logic      sclk_rise;
    logic      sclk_fall;
    logic [2:0] bit_cnt;
    spi_byte_t rx_shift;
    spi_byte_t tx_shift;

    assign sclk_s    = sclk_sync[`SPI_SYNC_STAGES-1];
    assign sclk_prev = sclk_sync[`SPI_SYNC_STAGES];
    assign mosi_s    = mosi_sync[`SPI_SYNC_STAGES-1];

    assign sclk_rise = sclk_s & ~sclk_prev;
    assign sclk_fall = ~sclk_s & sclk_prev;

    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            sclk_sync <= '0;    // idle clock is low in mode 0.
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[`SPI_SYNC_STAGES-1:0], spi_sclk_i};
            mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], spi_rx_i};
        end
    end

    // bit counter and the byte strobe.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= sclk_rise && (bit_cnt == 3'd7);
            if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;    // wraps after eight bits.
            end
        end
    end

    // receive side, msb first.
    always_ff @(posedge clk_sys_i) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_s};
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_shift[6:0], mosi_s};
            end
        end
    end

    // transmit side. The falling edge that ends a byte comes with
    // bit_cnt already wrapped to zero and must not shift the new load.
    always_ff @(posedge clk_sys_i) begin
        if (spi_cs_ni || rx_valid_o) begin
            tx_shift <= tx_byte_i;
        end else if (sclk_fall && (bit_cnt != 3'd0)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign spi_tx_o = tx_shift[7];    // msb on the line right after load.

    // a byte takes at least sixteen system cycles, never two strobes in a row.
    a_rx_valid_pulse: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
            rx_valid_o |=> !rx_valid_o
    ) else $error("rx_valid_o high for two cycles");

endmodule

// ==== rtl/spi_bridge.sv ====
`timescale 1ns/100ps
`include "spi_bridge_defines.svh"

module spi_bridge (
    input  logic                      clk_sys_i,
    input  logic                      spi_cs_ni,
    input  spi_bridge_pkg::spi_byte_t rx_byte_i,
    input  logic                      rx_valid_i,
    output spi_bridge_pkg::spi_byte_t tx_byte_o,
    output logic                      xfer_done_o,
    mem_bus_if.bridge                 bus
);
    import spi_bridge_pkg::*;

    localparam int A16 = `SPI_ADDR_WIDTH - 1;

    bridge_state_e state;
    bus_addr_t     addr_q;      // kept across frames for auto increment.
    spi_byte_t     wdata_q;
    spi_byte_t     rdata_q;     // returned as first byte of next frame.
    logic          rw_n_q;
    logic          load_addr_q;

    // command byte.
    //   bit 7 : 1 = read, 0 = write.
    //   bit 6 : address bytes follow, bit 0 is A16.
    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            state <= READ_CMD;
        end else begin
            case (state)
                READ_CMD: begin
                    if (rx_valid_i) begin
                        unique casez (rx_byte_i[7:6])
                            2'b0?:   state <= READ_DATA_ARG;
                            2'b11:   state <= READ_ADDR_HI_ARG;
                            default: state <= XFER;    // read at current address.
                        endcase
                    end
                end

                READ_DATA_ARG: begin
                    if (rx_valid_i) begin
                        state <= load_addr_q ? READ_ADDR_HI_ARG : XFER;
                    end
                end

                READ_ADDR_HI_ARG: begin
                    if (rx_valid_i) begin
                        state <= READ_ADDR_LO_ARG;
                    end
                end

                READ_ADDR_LO_ARG: begin
                    if (rx_valid_i) begin
                        state <= XFER;
                    end
                end

                XFER: begin
                    if (bus.ready) begin
                        state <= DONE;
                    end
                end

                default: begin
                    state <= DONE;    // wait here for chip select.
                end
            endcase
        end
    end

    // command, address and data registers.
    always_ff @(posedge clk_sys_i) begin
        case (state)
            READ_CMD: begin
                if (rx_valid_i) begin
                    rw_n_q      <= rx_byte_i[7];
                    load_addr_q <= rx_byte_i[6];
                    if (rx_byte_i[6]) begin
                        addr_q[A16] <= rx_byte_i[0];    // bank select.
                    end
                end
            end

            READ_DATA_ARG: begin
                if (rx_valid_i) begin
                    wdata_q <= rx_byte_i;
                end
            end

            READ_ADDR_HI_ARG: begin
                if (rx_valid_i) begin
                    addr_q[15:8] <= rx_byte_i;
                end
            end

            READ_ADDR_LO_ARG: begin
                if (rx_valid_i) begin
                    addr_q[7:0] <= rx_byte_i;
                end
            end

            XFER: begin
                if (bus.ready) begin
                    addr_q <= addr_q + bus_addr_t'(1);
                    if (rw_n_q) begin
                        rdata_q <= bus.rdata;
                    end
                end
            end

            default: begin
            end
        endcase
    end

    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.rw_n  = rw_n_q;
    assign bus.valid = state[2];    // XFER.
    assign xfer_done_o = state[3];  // DONE.
    assign tx_byte_o = rdata_q;

    // the request may not move or drop until the memory answers.
    a_req_held: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
            bus.valid && !bus.ready |=>
                bus.valid && $stable(bus.addr) && $stable(bus.wdata) && $stable(bus.rw_n)
    ) else $error("memory request changed before ready");

    a_done_excl: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
            !(xfer_done_o && bus.valid)
    ) else $error("xfer_done_o high while request pending");

endmodule

// ==== rtl/sram_port.sv ====
`timescale 1ns/100ps
`include "spi_bridge_defines.svh"

module sram_port #(
    parameter int WAIT_CYCLES = `SRAM_WAIT_CYCLES
) (
    input  logic       clk_sys_i,
    input  logic       spi_cs_ni,
    mem_bus_if.memory  bus
);
    import spi_bridge_pkg::*;

    localparam int DEPTH = 2 ** `SPI_ADDR_WIDTH;
    localparam int CNT_W = $clog2(WAIT_CYCLES + 2);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_CYCLES);

    spi_byte_t        mem [DEPTH];
    logic [CNT_W-1:0] wait_cnt;
    logic             ready_q;
    spi_byte_t        rdata_q;
    logic             answer;

    // last wait state reached, ready shows on the next cycle.
    assign answer = bus.valid && !ready_q && (wait_cnt == CNT_LAST);

    always_ff @(posedge clk_sys_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            wait_cnt <= '0;
            ready_q  <= 1'b0;
        end else if (ready_q) begin
            wait_cnt <= '0;     // single pulse, then start over.
            ready_q  <= 1'b0;
        end else if (answer) begin
            ready_q <= 1'b1;
        end else if (bus.valid) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // storage. Writes land on the ready edge.
    always_ff @(posedge clk_sys_i) begin
        if (answer) begin
            rdata_q <= mem[bus.addr];
        end
        if (ready_q && !bus.rw_n) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = rdata_q;

    a_ready_needs_valid: assert property (
        @(posedge clk_sys_i) disable iff (spi_cs_ni)
            bus.ready |-> bus.valid
    ) else $error("ready without a pending request");

endmodule

// ==== rtl/spi_sram_top.sv ====
`timescale 1ns/100ps

module spi_sram_top (
    input  logic clk_sys_i,
    input  logic spi_sclk_i,
    input  logic spi_cs_ni,     // high between frames, also the reset.
    input  logic spi_rx_i,
    output logic spi_tx_o,
    output logic xfer_done_o
);
    import spi_bridge_pkg::*;

    spi_byte_t rx_byte;
    logic      rx_valid;
    spi_byte_t tx_byte;

    mem_bus_if u_mem_bus ();

    // pins to bytes.
    spi_byte u_spi_byte (
        .clk_sys_i  (clk_sys_i),
        .spi_sclk_i (spi_sclk_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_rx_i   (spi_rx_i),
        .spi_tx_o   (spi_tx_o),
        .tx_byte_i  (tx_byte),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    // bytes to one memory transfer per frame.
    spi_bridge u_spi_bridge (
        .clk_sys_i   (clk_sys_i),
        .spi_cs_ni   (spi_cs_ni),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .tx_byte_o   (tx_byte),
        .xfer_done_o (xfer_done_o),
        .bus         (u_mem_bus.bridge)
    );

    sram_port u_sram_port (
        .clk_sys_i (clk_sys_i),
        .spi_cs_ni (spi_cs_ni),
        .bus       (u_mem_bus.memory)
    );

endmodule

// ==== bench/tb_spi_sram.sv ====
`timescale 1ns/100ps
`include "spi_bridge_defines.svh"

module tb_spi_sram;
    import spi_bridge_pkg::*;

    localparam int HALF_SCLK   = 5;     // system clocks per sclk half period.
    localparam int DONE_LIMIT  = 50;
    localparam int RAND_WRITES = 40;

    logic clk_sys;
    logic spi_sclk;
    logic spi_cs_n;
    logic spi_mosi;
    logic spi_miso;
    logic xfer_done;

    spi_byte_t frame_tx [4];    // bytes sent in the current frame.
    spi_byte_t frame_rx [4];    // bytes seen on miso in the current frame.

    spi_byte_t ref_mem [2 ** `SPI_ADDR_WIDTH];
    bus_addr_t cur_addr;        // model of the bridge address register.
    bus_addr_t rand_addr [RAND_WRITES];

    // a read shows up as the first miso byte of the following frame.
    logic      pend_valid;
    bus_addr_t pend_addr;
    spi_byte_t pend_data;

    logic [31:0] rng;
    int          err_cnt;
    int          timeout_cnt;

    spi_sram_top u_dut (
        .clk_sys_i   (clk_sys),
        .spi_sclk_i  (spi_sclk),
        .spi_cs_ni   (spi_cs_n),
        .spi_rx_i    (spi_mosi),
        .spi_tx_o    (spi_miso),
        .xfer_done_o (xfer_done)
    );

    always #20 clk_sys = ~clk_sys;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_pending(input spi_byte_t got);
        if (pend_valid) begin
            assert (got === pend_data) else begin
                $display("Error at %0t: read of 0x%05h returned 0x%02h, expected 0x%02h",
                         $time, pend_addr, got, pend_data);
                err_cnt++;
            end
            pend_valid = 1'b0;
        end
    endtask

    task automatic wait_done();
        int  n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < DONE_LIMIT && !seen; n++) begin
            @(posedge clk_sys);
            if (xfer_done) begin
                seen = 1'b1;
            end
        end
        assert (seen) else begin
            $display("timeout: xfer_done_o stayed low for %0d cycles at %0t",
                     DONE_LIMIT, $time);
            timeout_cnt++;
        end
    endtask

    // mode 0 master. Mosi changes with the falling edge, miso is taken
    // just before the rising edge.
    task automatic spi_frame(input int nbits, input logic need_done);
        int k;
        @(posedge clk_sys);
        spi_cs_n <= 1'b0;
        repeat (2) @(posedge clk_sys);
        for (k = 0; k < nbits; k++) begin
            spi_mosi <= frame_tx[k / 8][7 - (k % 8)];
            repeat (HALF_SCLK) @(posedge clk_sys);
            frame_rx[k / 8][7 - (k % 8)] = spi_miso;
            spi_sclk <= 1'b1;
            repeat (HALF_SCLK) @(posedge clk_sys);
            spi_sclk <= 1'b0;
        end
        if (need_done) begin
            wait_done();
        end
        @(posedge clk_sys);
        spi_cs_n <= 1'b1;
        spi_mosi <= 1'b0;
        repeat (2) @(posedge clk_sys);
        if (nbits >= 8) begin
            check_pending(frame_rx[0]);
        end
    endtask

    task automatic write_at(input bus_addr_t addr, input spi_byte_t data);
        frame_tx[0] = 8'h40 | {7'd0, addr[`SPI_ADDR_WIDTH-1]};
        frame_tx[1] = data;
        frame_tx[2] = addr[15:8];
        frame_tx[3] = addr[7:0];
        spi_frame(32, 1'b1);
        ref_mem[addr] = data;
        cur_addr = addr + 1'b1;
    endtask

    task automatic write_next(input spi_byte_t data);
        frame_tx[0] = 8'h00;
        frame_tx[1] = data;
        spi_frame(16, 1'b1);
        ref_mem[cur_addr] = data;
        cur_addr = cur_addr + 1'b1;
    endtask

    task automatic read_at(input bus_addr_t addr);
        frame_tx[0] = 8'hc0 | {7'd0, addr[`SPI_ADDR_WIDTH-1]};
        frame_tx[1] = addr[15:8];
        frame_tx[2] = addr[7:0];
        spi_frame(24, 1'b1);
        pend_valid = 1'b1;
        pend_addr  = addr;
        pend_data  = ref_mem[addr];
        cur_addr   = addr + 1'b1;
    endtask

    task automatic read_next();
        frame_tx[0] = 8'h80;
        spi_frame(8, 1'b1);
        pend_valid = 1'b1;
        pend_addr  = cur_addr;
        pend_data  = ref_mem[cur_addr];
        cur_addr   = cur_addr + 1'b1;
    endtask

    // write command alone, dropped before its data byte, so only miso matters.
    task automatic collect_read();
        frame_tx[0] = 8'h00;
        spi_frame(8, 1'b0);
    endtask

    task automatic test_write_read();
        $display("test: write then read");
        write_at(17'h00a5c, 8'h96);
        read_at(17'h00a5c);
        collect_read();
    endtask

    task automatic test_auto_increment();
        bus_addr_t start;
        start = 17'h01ffe;    // low byte carries into the high byte.
        $display("test: auto increment");
        write_at(start, 8'h11);
        write_next(8'h22);
        write_next(8'h33);
        write_next(8'h44);
        read_at(start);
        read_next();
        read_next();
        read_next();
        collect_read();
    endtask

    task automatic test_bank_select();
        $display("test: bank select");
        write_at({1'b0, 16'h4321}, 8'h5a);
        write_at({1'b1, 16'h4321}, 8'ha5);
        read_at({1'b0, 16'h4321});
        read_at({1'b1, 16'h4321});
        collect_read();
    endtask

    task automatic test_aborted_frame();
        bus_addr_t addr;
        addr = 17'h10777;
        $display("test: aborted frame");
        write_at(addr, 8'h3c);
        frame_tx[0] = 8'h40;
        frame_tx[1] = 8'hc3;
        spi_frame(9, 1'b0);    // command plus one data bit.
        assert (xfer_done === 1'b0) else begin
            $display("Error at %0t: xfer_done_o is %b after an aborted frame",
                     $time, xfer_done);
            err_cnt++;
        end
        read_at(addr);
        collect_read();
    endtask

    task automatic test_random_traffic();
        int        i;
        spi_byte_t data;
        $display("test: random traffic");
        for (i = 0; i < RAND_WRITES; i++) begin
            rng = lcg_step(rng);
            rand_addr[i] = rng[24:8];
            rng = lcg_step(rng);
            data = rng[23:16];
            write_at(rand_addr[i], data);
        end
        for (i = 0; i < RAND_WRITES; i++) begin
            read_at(rand_addr[i]);    // checks the read before it.
        end
        collect_read();
    endtask

    initial begin
        clk_sys     = 1'b0;
        spi_sclk    = 1'b0;
        spi_cs_n    = 1'b1;    // chip select high is the reset.
        spi_mosi    = 1'b0;
        pend_valid  = 1'b0;
        pend_addr   = '0;
        pend_data   = '0;
        cur_addr    = '0;
        rng         = 32'd94785;
        err_cnt     = 0;
        timeout_cnt = 0;
        repeat (2) @(posedge clk_sys);

        test_write_read();
        test_auto_increment();
        test_bank_select();
        test_aborted_frame();
        test_random_traffic();

        $display("summary: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/spi_bridge_pkg.sv
rtl/mem_bus_if.sv
rtl/spi_byte.sv
rtl/spi_bridge.sv
rtl/sram_port.sv
rtl/spi_sram_top.sv
bench/tb_spi_sram.sv
